// File: Bender.yml
package:
  name: debug_scan_port

sources:
  - files:
      - design/DebugScanPkg.sv
      - design/TapController.sv
      - design/ScanDataReg.sv
      - design/BoundaryScan.sv
      - design/ScanChainSelect.sv
      - design/DebugScanPort.sv
  - target: test
    files:
      - tests/DebugScanPort_assert.sv
      - tests/DebugScanPort_tb.sv

// File: compile.f
design/DebugScanPkg.sv
design/TapController.sv
design/ScanDataReg.sv
design/BoundaryScan.sv
design/ScanChainSelect.sv
design/DebugScanPort.sv
tests/DebugScanPort_assert.sv
tests/DebugScanPort_tb.sv

// File: design/BoundaryScan.sv
// Read-only boundary chain; probes must be stable two edges before the Capture-DR edge and the pad reads zero.
`timescale 1ns/10ps
`default_nettype none

module BoundaryScan import DebugScanPkg::*; (
	input  wire logic   i_clk,
	input  wire logic   i_rst,

	// Gated DR strobes.
	input  wire logic   i_capture,
	input  wire logic   i_shift,

	input  wire logic   i_tdi,
	output logic        o_tdo,

	// Probed subsystem lines.
	input  wire probe_t i_probe
);

	// First sync stage.
	probe_t sampleQ;

	// Probe part of the chain.
	logic [PROBE_WIDTH-1:0] chainQ;

	// Alignment pad after the chain.
	logic [BSR_PAD-1:0] padQ;

	// ----------------------------------------------------------
	// Sample stage.
	// ----------------------------------------------------------

	// Free running copy of the probes.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sampleQ <= '0;
		end else begin
			sampleQ <= i_probe;
		end
	end

	// ----------------------------------------------------------
	// Probe chain.
	// ----------------------------------------------------------

	// Second sync stage on capture.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			chainQ <= '0;
		end else if (i_capture) begin
			chainQ <= sampleQ;
		end else if (i_shift) begin
			chainQ <= {chainQ[PROBE_WIDTH-2:0], i_tdi};
		end
	end

	// ----------------------------------------------------------
	// Alignment pad.
	// ----------------------------------------------------------

	// Cleared on capture so it reads back as zeros.
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			padQ <= '0;
		end else if (i_capture) begin
			padQ <= '0;
		end else if (i_shift) begin
			// Fed from the chain's top bit.
			padQ <= {padQ[BSR_PAD-2:0], chainQ[PROBE_WIDTH-1]};
		end
	end

	// Pad top bit is the end of the whole register.
	assign o_tdo = padQ[BSR_PAD-1];

endmodule

`default_nettype wire

// File: design/DebugScanPkg.sv
// Shared scan types and constants. Single clock domain only; IR width and chain lengths are fixed here.
`default_nettype none

package DebugScanPkg;

	// ----------------------------------------------------------
	// TAP controller states.
	// ----------------------------------------------------------

	// IEEE 1149.1 style encoding.
	typedef enum logic [3:0] {
		stExit2Dr     = 4'h0,
		stExit1Dr     = 4'h1,
		stShiftDr     = 4'h2,
		stPauseDr     = 4'h3,
		stSelectIr    = 4'h4,
		stUpdateDr    = 4'h5,
		stCaptureDr   = 4'h6,
		stSelectDr    = 4'h7,
		stExit2Ir     = 4'h8,
		stExit1Ir     = 4'h9,
		stShiftIr     = 4'hA,
		stPauseIr     = 4'hB,
		stIdle        = 4'hC,
		stUpdateIr    = 4'hD,
		stCaptureIr   = 4'hE,
		stReset       = 4'hF
	} tapState_t;

	// ----------------------------------------------------------
	// Instruction register.
	// ----------------------------------------------------------
	localparam int IR_WIDTH = 4;

	// Unlisted codes act as BYPASS.
	typedef enum logic [IR_WIDTH-1:0] {
		IDCODE = 4'b0001,
		SAMPLE = 4'b0010,
		BYPASS = 4'b1111
	} instr_t;

	// Fixed pattern loaded in Capture-IR.
	localparam instr_t IR_CAPTURE = instr_t'(4'b0001);

	// Version 1, part 0x5CA0, manufacturer 0x2A5, marker bit set.
	localparam logic [31:0] IDCODE_VALUE = {4'h1, 16'h5CA0, 11'h2A5, 1'b1};

	// ----------------------------------------------------------
	// Boundary register.
	// ----------------------------------------------------------

	// Probe snapshot, top bit first.
	typedef struct packed {
		logic        smIsPaused;
		logic        smIsBooted;
		logic        smDoPause;
		logic [15:0] gpioPins;
		logic        spiCSn;
		logic        spiCLK;
		logic        spiMOSI;
		logic        spiMISO;
		logic        memEn;
		logic        memWr;
		logic [15:0] memData;
		logic [15:0] memAddr;
	} probe_t;

	localparam int PROBE_WIDTH = $bits(probe_t);
	// Zero pad to reach a whole number of bytes.
	localparam int BSR_PAD     = 7;
	localparam int BSR_LENGTH  = PROBE_WIDTH + BSR_PAD;

endpackage

`default_nettype wire

// File: design/DebugScanPort.sv
// Read-only debug scan port top; single clock, synchronous reset, no pin drive and no falling-edge TDO.
`timescale 1ns/10ps
`default_nettype none

module DebugScanPort import DebugScanPkg::*; (
	input  wire logic   i_clk,
	input  wire logic   i_rst,

	// Serial scan pins.
	input  wire logic   i_tms,
	input  wire logic   i_tdi,
	output logic        o_tdo,
	output logic        o_tdoEn,

	// Probed subsystem lines.
	input  wire probe_t i_probe
);

	// ----------------------------------------------------------
	// Internal wiring.
	// ----------------------------------------------------------

	// TAP strobes.
	logic   tapReset;
	logic   captureDr;
	logic   shiftDr;
	logic   captureIr;
	logic   shiftIr;
	logic   updateIr;

	// Instruction chain.
	instr_t irValue;
	logic   irTdo;

	// IDCODE chain.
	logic   idCapture;
	logic   idShift;
	logic   idTdo;

	// Boundary chain.
	logic   bsCapture;
	logic   bsShift;
	logic   bsTdo;

	// ----------------------------------------------------------
	// TAP controller.
	// ----------------------------------------------------------
	TapController tap0 (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_tms       (i_tms),
		.o_state     (),
		.o_tapReset  (tapReset),
		.o_captureDr (captureDr),
		.o_shiftDr   (shiftDr),
		.o_updateDr  (),
		.o_captureIr (captureIr),
		.o_shiftIr   (shiftIr),
		.o_updateIr  (updateIr),
		.o_tdoEn     (o_tdoEn)
	);

	// ----------------------------------------------------------
	// Data chains.
	// ----------------------------------------------------------

	// Instruction register runs straight off the IR strobes.
	ScanDataReg #(
		.T             (instr_t),
		.CAPTURE_VALUE (IR_CAPTURE)
	) irReg (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_capture    (captureIr),
		.i_shift      (shiftIr),
		.i_tdi        (i_tdi),
		.o_tdo        (irTdo),
		.o_shiftValue (irValue)
	);

	ScanDataReg #(
		.T             (logic [31:0]),
		.CAPTURE_VALUE (IDCODE_VALUE)
	) idReg (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_capture    (idCapture),
		.i_shift      (idShift),
		.i_tdi        (i_tdi),
		.o_tdo        (idTdo),
		.o_shiftValue ()
	);

	BoundaryScan bsr0 (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_capture (bsCapture),
		.i_shift   (bsShift),
		.i_tdi     (i_tdi),
		.o_tdo     (bsTdo),
		.i_probe   (i_probe)
	);

	// ----------------------------------------------------------
	// Chain select and TDO.
	// ----------------------------------------------------------
	ScanChainSelect sel0 (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_tapReset  (tapReset),
		.i_captureDr (captureDr),
		.i_shiftDr   (shiftDr),
		.i_updateIr  (updateIr),
		.i_shiftIr   (shiftIr),
		.i_tdi       (i_tdi),
		.i_irValue   (irValue),
		.i_irTdo     (irTdo),
		.i_idTdo     (idTdo),
		.i_bsTdo     (bsTdo),
		.o_idCapture (idCapture),
		.o_idShift   (idShift),
		.o_bsCapture (bsCapture),
		.o_bsShift   (bsShift),
		.o_tdo       (o_tdo)
	);

endmodule

`default_nettype wire

// File: design/ScanChainSelect.sv
// Instruction latch and DR routing; unknown instruction codes select the bypass bit and TAP reset forces IDCODE.
`timescale 1ns/10ps
`default_nettype none

module ScanChainSelect import DebugScanPkg::*; (
	input  wire logic   i_clk,
	input  wire logic   i_rst,

	// TAP strobes.
	input  wire logic   i_tapReset,
	input  wire logic   i_captureDr,
	input  wire logic   i_shiftDr,
	input  wire logic   i_updateIr,
	input  wire logic   i_shiftIr,

	input  wire logic   i_tdi,

	// Shifted instruction from the IR chain.
	input  wire instr_t i_irValue,

	// Chain outputs.
	input  wire logic   i_irTdo,
	input  wire logic   i_idTdo,
	input  wire logic   i_bsTdo,

	// Per-chain enables.
	output logic        o_idCapture,
	output logic        o_idShift,
	output logic        o_bsCapture,
	output logic        o_bsShift,

	output logic        o_tdo
);

	instr_t curInstr;
	logic   bypassQ;
	logic   selId;
	logic   selBs;
	logic   selBypass;

	// ----------------------------------------------------------
	// Current instruction.
	// ----------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst || i_tapReset) begin
			curInstr <= IDCODE;
		end else if (i_updateIr) begin
			curInstr <= i_irValue;
		end
	end

	// Decode. Anything else is bypass.
	assign selId     = (curInstr == IDCODE);
	assign selBs     = (curInstr == SAMPLE);
	assign selBypass = !selId && !selBs;

	// ----------------------------------------------------------
	// Bypass bit.
	// ----------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			bypassQ <= 1'b0;
		end else if (i_captureDr && selBypass) begin
			bypassQ <= 1'b0;
		end else if (i_shiftDr && selBypass) begin
			bypassQ <= i_tdi;
		end
	end

	// ----------------------------------------------------------
	// Enables and TDO mux.
	// ----------------------------------------------------------
	assign o_idCapture = i_captureDr && selId;
	assign o_idShift   = i_shiftDr && selId;
	assign o_bsCapture = i_captureDr && selBs;
	assign o_bsShift   = i_shiftDr && selBs;

	// IR chain has priority while in Shift-IR.
	assign o_tdo = i_shiftIr ? i_irTdo :
	               selId     ? i_idTdo :
	               selBs     ? i_bsTdo : bypassQ;

endmodule

`default_nettype wire

// File: design/ScanDataReg.sv
// Generic capture/shift register; capture wins over shift and the payload type must be at least 2 bits.
`timescale 1ns/10ps
`default_nettype none

module ScanDataReg #(
	parameter type T             = logic [31:0],
	parameter T    CAPTURE_VALUE = '0
) (
	input  wire logic i_clk,
	input  wire logic i_rst,

	// Strobes from the TAP or the chain selector.
	input  wire logic i_capture,
	input  wire logic i_shift,

	input  wire logic i_tdi,
	output logic      o_tdo,

	// Parallel view of the shifted contents.
	output T          o_shiftValue
);

	// Held as a plain vector so enum payloads shift cleanly.
	logic [$bits(T)-1:0] shiftReg;

	// ----------------------------------------------------------
	// Capture and shift.
	// ----------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			shiftReg <= '0;
		end else if (i_capture) begin
			shiftReg <= CAPTURE_VALUE;
		end else if (i_shift) begin
			// TDI enters at bit 0.
			shiftReg <= {shiftReg[$bits(T)-2:0], i_tdi};
		end
	end

	// ----------------------------------------------------------
	// Outputs.
	// ----------------------------------------------------------

	// MSB leaves first.
	assign o_tdo = shiftReg[$bits(T)-1];

	assign o_shiftValue = T'(shiftReg);

endmodule

`default_nettype wire

// File: design/TapController.sv
// TAP state machine on i_clk with synchronous reset only; no TRST pin and all strobes are Moore decodes.
`timescale 1ns/10ps
`default_nettype none

module TapController import DebugScanPkg::*; (
	input  wire logic i_clk,
	input  wire logic i_rst,
	input  wire logic i_tms,

	output tapState_t o_state,
	output logic      o_tapReset,
	output logic      o_captureDr,
	output logic      o_shiftDr,
	output logic      o_updateDr,
	output logic      o_captureIr,
	output logic      o_shiftIr,
	output logic      o_updateIr,
	output logic      o_tdoEn
);

	tapState_t state;
	tapState_t stateNext;

	// ----------------------------------------------------------
	// State register.
	// ----------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= stReset;
		end else begin
			state <= stateNext;
		end
	end

	// ----------------------------------------------------------
	// Transition table.
	// ----------------------------------------------------------

	// Five TMS-high edges reach reset from any state.
	always_comb begin
		case (state)
			stReset:     stateNext = i_tms ? stReset    : stIdle;
			stIdle:      stateNext = i_tms ? stSelectDr : stIdle;

			// Data column.
			stSelectDr:  stateNext = i_tms ? stSelectIr : stCaptureDr;
			stCaptureDr: stateNext = i_tms ? stExit1Dr  : stShiftDr;
			stShiftDr:   stateNext = i_tms ? stExit1Dr  : stShiftDr;
			stExit1Dr:   stateNext = i_tms ? stUpdateDr : stPauseDr;
			stPauseDr:   stateNext = i_tms ? stExit2Dr  : stPauseDr;
			stExit2Dr:   stateNext = i_tms ? stUpdateDr : stShiftDr;
			stUpdateDr:  stateNext = i_tms ? stSelectDr : stIdle;

			// Instruction column.
			stSelectIr:  stateNext = i_tms ? stReset    : stCaptureIr;
			stCaptureIr: stateNext = i_tms ? stExit1Ir  : stShiftIr;
			stShiftIr:   stateNext = i_tms ? stExit1Ir  : stShiftIr;
			stExit1Ir:   stateNext = i_tms ? stUpdateIr : stPauseIr;
			stPauseIr:   stateNext = i_tms ? stExit2Ir  : stPauseIr;
			stExit2Ir:   stateNext = i_tms ? stUpdateIr : stShiftIr;
			stUpdateIr:  stateNext = i_tms ? stSelectDr : stIdle;

			// Unreachable.
			default:     stateNext = stReset;
		endcase
	end

	// ----------------------------------------------------------
	// Moore strobes.
	// ----------------------------------------------------------
	assign o_state     = state;
	assign o_tapReset  = (state == stReset);

	assign o_captureDr = (state == stCaptureDr);
	assign o_shiftDr   = (state == stShiftDr);
	assign o_updateDr  = (state == stUpdateDr);

	assign o_captureIr = (state == stCaptureIr);
	assign o_shiftIr   = (state == stShiftIr);
	assign o_updateIr  = (state == stUpdateIr);

	// TDO only valid while shifting.
	assign o_tdoEn = o_shiftDr | o_shiftIr;

endmodule

`default_nettype wire

// File: tests/DebugScanPort_assert.sv
// Bound to every TapController; checks the strobe decode and reset entry, not the transition table.
`timescale 1ns/10ps
`default_nettype none

module DebugScanPort_assert import DebugScanPkg::*; (
	input wire logic      i_clk,
	input wire logic      i_rst,
	input wire tapState_t i_state,
	input wire logic      i_tapReset,
	input wire logic      i_captureDr,
	input wire logic      i_shiftDr,
	input wire logic      i_updateDr,
	input wire logic      i_captureIr,
	input wire logic      i_shiftIr,
	input wire logic      i_updateIr,
	input wire logic      i_tdoEn
);

	// Failed assertions so far.
	int failures = 0;

	// ----------------------------------------------------------
	// Strobe decode.
	// ----------------------------------------------------------

	// One state, so one strobe at most.
	strobeExclusive: assert property (@(posedge i_clk) disable iff (i_rst)
		$onehot0({i_tapReset, i_captureDr, i_shiftDr, i_updateDr,
			i_captureIr, i_shiftIr, i_updateIr}))
		else begin
			failures++;
			$error("More than one TAP strobe high in one cycle");
		end

	// TDO enable only in the two shift states.
	tdoEnMatch: assert property (@(posedge i_clk) disable iff (i_rst)
		i_tdoEn == (i_state == stShiftDr || i_state == stShiftIr))
		else begin
			failures++;
			$error("TDO enable differs from the shift states");
		end

	// ----------------------------------------------------------
	// Reset entry.
	// ----------------------------------------------------------
	resetState: assert property (@(posedge i_clk) i_rst |=> i_state == stReset)
		else begin
			failures++;
			$error("TAP not in Test-Logic-Reset after reset");
		end

endmodule

bind TapController DebugScanPort_assert assert0 (
	.i_clk       (i_clk),
	.i_rst       (i_rst),
	.i_state     (o_state),
	.i_tapReset  (o_tapReset),
	.i_captureDr (o_captureDr),
	.i_shiftDr   (o_shiftDr),
	.i_updateDr  (o_updateDr),
	.i_captureIr (o_captureIr),
	.i_shiftIr   (o_shiftIr),
	.i_updateIr  (o_updateIr),
	.i_tdoEn     (o_tdoEn)
);

`default_nettype wire

// File: tests/DebugScanPort_tb.sv
// Drives the port through TMS/TDI only; every scan starts and ends in Run-Test/Idle, 128-bit streams max.
`timescale 1ns/10ps
`default_nettype none

module DebugScanPort_tb import DebugScanPkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RST_CYCLES  = 10;
	localparam int SEED        = 77874;

	// Scan operations, a 64-bit scan counting as two and a 128-bit scan as four.
	localparam int NUM_OPS         = 21;
	localparam int OP_CYCLES       = 40;
	localparam int WATCHDOG_CYCLES = NUM_OPS * OP_CYCLES + RST_CYCLES;

	logic   clk;
	logic   rst;
	logic   tms;
	logic   tdi;
	probe_t probe;
	logic   tdo;
	logic   tdoEn;
	int     errors;
	int     checks;

	DebugScanPort dut0 (
		.i_clk   (clk),
		.i_rst   (rst),
		.i_tms   (tms),
		.i_tdi   (tdi),
		.o_tdo   (tdo),
		.o_tdoEn (tdoEn),
		.i_probe (probe)
	);

	// ----------------------------------------------------------
	// Clock and watchdog.
	// ----------------------------------------------------------
	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the scan sequence finished");
		$display("TB FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// Reference model.
	// ----------------------------------------------------------

	// Version, part, manufacturer, marker bit.
	function automatic logic [31:0] expectedIdcode();
		return {4'h1, 16'h5CA0, 11'h2A5, 1'b1};
	endfunction

	// Pad zeros leave first, then the probe struct MSB first.
	function automatic logic [63:0] expectedBoundary(input probe_t p);
		return {7'b0, p};
	endfunction

	// Register of length len: captured bits first, then TDI delayed by len.
	function automatic logic [127:0] expectedStream(input logic [127:0] captured, input int len,
			input logic [127:0] tdiBits, input int n);
		logic [127:0] res;
		res = '0;
		for (int i = 0; i < n; i++) begin
			if (i < len) begin
				res[n-1-i] = captured[len-1-i];
			end else begin
				res[n-1-i] = tdiBits[n-1-(i-len)];
			end
		end
		return res;
	endfunction

	// ----------------------------------------------------------
	// Compare tasks.
	// ----------------------------------------------------------
	task automatic checkBit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic checkInstr(input string name, input instr_t exp, input instr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic checkProbe(input string name, input probe_t exp, input probe_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Long streams go word by word.
	task automatic checkStream(input string name, input logic [127:0] exp,
			input logic [127:0] act, input int n);
		for (int w = 0; w < n / 32; w++) begin
			checkWord($sformatf("%s word %0d", name, w), exp[w*32 +: 32], act[w*32 +: 32]);
		end
	endtask

	// ----------------------------------------------------------
	// TMS/TDI sequencing.
	// ----------------------------------------------------------

	// One TAP clock. Inputs change just after the rising edge.
	task automatic clockTap(input logic tmsVal, input logic tdiVal);
		tms = tmsVal;
		tdi = tdiVal;
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// TMS path, leftmost bit first.
	task automatic moveTap(input logic [7:0] path, input int len);
		for (int i = len - 1; i >= 0; i--) begin
			clockTap(path[i], 1'b0);
		end
	endtask

	// Starts in Shift-xR, ends in Exit1-xR. Bit n-1 travels first.
	task automatic shiftBits(input int n, input logic [127:0] tdiBits,
			output logic [127:0] tdoBits);
		tdoBits = '0;
		for (int i = 0; i < n; i++) begin
			tdoBits[n-1-i] = tdo;
			clockTap(i == n - 1, tdiBits[n-1-i]);
		end
	endtask

	// Idle to Idle through Update-DR.
	task automatic scanDr(input int n, input logic [127:0] tdiBits,
			output logic [127:0] tdoBits);
		moveTap(8'b100, 3);
		checkBit("tdoEn in Shift-DR", 1'b1, tdoEn);
		shiftBits(n, tdiBits, tdoBits);
		moveTap(8'b10, 2);
	endtask

	// Idle to Idle through Update-IR.
	task automatic scanIr(input int n, input logic [127:0] tdiBits,
			output logic [127:0] tdoBits);
		moveTap(8'b1100, 4);
		checkBit("tdoEn in Shift-IR", 1'b1, tdoEn);
		shiftBits(n, tdiBits, tdoBits);
		moveTap(8'b10, 2);
	endtask

	// ----------------------------------------------------------
	// Test sequence.
	// ----------------------------------------------------------
	initial begin
		logic [127:0] sent;
		logic [127:0] got;
		logic [63:0]  raw;
		logic [63:0]  expBsr;
		probe_t       sampled;
		instr_t       code;
		int           assertFails;

		errors = 0;
		checks = 0;
		rst    = 1'b1;
		tms    = 1'b1;
		tdi    = 1'b0;
		probe  = '0;
		void'($urandom(SEED));

		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		checkBit("tdoEn after reset", 1'b0, tdoEn);
		moveTap(8'b0, 1);

		// Default instruction is IDCODE.
		scanDr(32, '0, got);
		checkWord("reset idcode", expectedIdcode(), got[31:0]);

		// Load SAMPLE. Captured IR pattern comes back.
		sent = '0;
		sent[3:0] = SAMPLE;
		scanIr(4, sent, got);
		checkInstr("ir capture", instr_t'(4'b0001), instr_t'(got[3:0]));
		checkBit("ir first bit out", 1'b0, got[3]);
		checkBit("ir last bit out", 1'b1, got[0]);

		// Random probe snapshots.
		for (int k = 0; k < 4; k++) begin
			raw = {$urandom(), $urandom()};
			sampled = probe_t'(raw[56:0]);
			probe = sampled;
			moveTap(8'b00, 2);
			scanDr(64, '0, got);
			expBsr = expectedBoundary(sampled);
			checkProbe($sformatf("boundary probe %0d", k), probe_t'(expBsr[56:0]),
				probe_t'(got[56:0]));
			checkWord("boundary pad", {25'b0, expBsr[63:57]}, {25'b0, got[63:57]});
		end

		// TDI comes out 64 shifts later.
		raw = {$urandom(), $urandom()};
		sampled = probe_t'(raw[56:0]);
		probe = sampled;
		moveTap(8'b00, 2);
		sent = {$urandom(), $urandom(), $urandom(), $urandom()};
		scanDr(128, sent, got);
		checkStream("chain length", expectedStream({64'b0, expectedBoundary(sampled)}, 64,
			sent, 128), got, 128);

		// BYPASS, then an unused code.
		for (int k = 0; k < 2; k++) begin
			code = (k == 0) ? BYPASS : instr_t'(4'b0101);
			sent = '0;
			sent[3:0] = code;
			scanIr(4, sent, got);
			checkInstr("ir capture before bypass", instr_t'(4'b0001), instr_t'(got[3:0]));
			sent = '0;
			sent[31:0] = $urandom();
			scanDr(32, sent, got);
			checkStream($sformatf("bypass %0d", k), expectedStream('0, 1, sent, 32), got, 32);
		end

		// Five TMS-high clocks from Pause-DR.
		sent = '0;
		sent[3:0] = SAMPLE;
		scanIr(4, sent, got);
		moveTap(8'b100, 3);
		moveTap(8'b10, 2);
		moveTap(8'b11111, 5);
		checkBit("tdoEn in Test-Logic-Reset", 1'b0, tdoEn);
		moveTap(8'b0, 1);
		scanDr(32, '0, got);
		checkWord("tms reset idcode", expectedIdcode(), got[31:0]);

		// Strobe assertions count their own failures.
		assertFails = dut0.tap0.assert0.failures;

		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
